// File: design/gamma_lut.sv
`default_nettype none

`include "led_panel_params.svh"

module gamma_lut (
    input  wire logic                   clk,
    input  wire logic                   ext_reset,
    pixel_pos_if.sink                   pos,
    input  wire led_panel_pkg::rgb24_t  rgb_top,
    input  wire led_panel_pkg::rgb24_t  rgb_bottom,
    color_if.source                     color
);

    typedef logic [`LP_GAMMA_BITS-1:0] gamma_table_t [0:(1 << `LP_COLOR_BITS) - 1];

    // square law, scaled to full 10 bit range and rounded
    function automatic gamma_table_t build_gamma();
        gamma_table_t t;
        int unsigned  v;
        for (int c = 0; c < (1 << `LP_COLOR_BITS); c++) begin
            v    = (c * c * 1023 + 32512) / 65025;
            t[c] = v[`LP_GAMMA_BITS-1:0];
        end
        return t;
    endfunction

    localparam gamma_table_t gamma_table = build_gamma();

    function automatic led_panel_pkg::rgb30_t correct(led_panel_pkg::rgb24_t c);
        led_panel_pkg::rgb30_t g;
        g.r = gamma_table[c.r];
        g.g = gamma_table[c.g];
        g.b = gamma_table[c.b];
        return g;
    endfunction

    always_ff @(posedge clk) begin
        color.rgb_top    <= correct(rgb_top);
        color.rgb_bottom <= correct(rgb_bottom);
        color.row        <= pos.row;    // position rides along with the data
        color.col        <= pos.col;
    end

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            color.valid <= 1'b0;
        end else begin
            color.valid <= pos.valid;
        end
    end

endmodule

`default_nettype wire

// File: design/led_panel_if.sv
`default_nettype none

`include "led_panel_params.svh"

// scan position, valid pulses once per new position
interface pixel_pos_if;
    logic [`LP_FRAME_BITS-1:0]    frame;
    logic [`LP_SUBFRAME_BITS-1:0] subframe;
    led_panel_pkg::row_t          row;
    led_panel_pkg::col_t          col;
    logic                         valid;

    modport source (output frame, subframe, row, col, valid);
    modport sink   (input  frame, subframe, row, col, valid);
endinterface

// gamma corrected colours for both halves of one column
interface color_if;
    led_panel_pkg::rgb30_t rgb_top;
    led_panel_pkg::rgb30_t rgb_bottom;
    led_panel_pkg::row_t   row;
    led_panel_pkg::col_t   col;
    logic                  valid;

    modport source (output rgb_top, rgb_bottom, row, col, valid);
    modport sink   (input  rgb_top, rgb_bottom, row, col, valid);
endinterface

`default_nettype wire

// File: design/led_panel_params.svh
`ifndef LED_PANEL_PARAMS_SVH
`define LED_PANEL_PARAMS_SVH

// panel geometry
`define LP_COLS          64
`define LP_COL_BITS      6
`define LP_ROW_BITS      5     // row pairs, top and bottom half share an address

// scan counter fields
`define LP_SUBFRAME_BITS 8
`define LP_FRAME_BITS    10

// colour channel widths
`define LP_COLOR_BITS    8     // from the pixel source
`define LP_GAMMA_BITS    10    // after gamma expansion

// error memory entries, one per row pair and column
`define LP_CLEAR_COUNT   2048

`endif

// File: design/led_panel_pkg.sv
`default_nettype none

`include "led_panel_params.svh"

package led_panel_pkg;

    typedef logic [`LP_COL_BITS-1:0] col_t;    // column index
    typedef logic [`LP_ROW_BITS-1:0] row_t;    // row pair address

    // pixel as returned by the source, red in the top byte
    typedef struct packed {
        logic [`LP_COLOR_BITS-1:0] r;
        logic [`LP_COLOR_BITS-1:0] g;
        logic [`LP_COLOR_BITS-1:0] b;
    } rgb24_t;

    typedef struct packed {
        logic [`LP_GAMMA_BITS-1:0] r;
        logic [`LP_GAMMA_BITS-1:0] g;
        logic [`LP_GAMMA_BITS-1:0] b;
    } rgb30_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb3_t;    // one subframe bit per channel

    typedef enum logic [2:0] {
        wait_clear,    // error memory still clearing
        shift_low,     // data set up, sclk low
        shift_high,    // sclk high, step the scan
        blank,
        latch,
        unblank
    } drv_state_t;

endpackage

`default_nettype wire

// File: design/led_panel_top.sv
`default_nettype none

`include "led_panel_params.svh"

module led_panel_top (
    input  wire logic                     clk,
    input  wire logic                     ext_reset,
    output logic [`LP_COL_BITS-1:0]       pixel_x,
    output logic [1:0][`LP_ROW_BITS:0]    pixel_y,          // [0] top half, [1] bottom
    output logic [`LP_FRAME_BITS-1:0]     pixel_frame,
    output logic [`LP_SUBFRAME_BITS-1:0]  pixel_subframe,
    input  wire led_panel_pkg::rgb24_t    rgb_top,
    input  wire led_panel_pkg::rgb24_t    rgb_bottom,
    output led_panel_pkg::rgb3_t          panel_rgb_top,
    output led_panel_pkg::rgb3_t          panel_rgb_bottom,
    output led_panel_pkg::row_t           panel_addr,
    output logic                          panel_blank,
    output logic                          panel_latch,
    output logic                          panel_sclk
);

    pixel_pos_if pos_bus ();
    color_if     color_bus ();

    logic                 step;
    logic                 mem_ready;
    led_panel_pkg::rgb3_t bits_top;
    led_panel_pkg::rgb3_t bits_bottom;
    led_panel_pkg::row_t  bits_row;
    logic                 bits_valid;

    // the source sees the same position for both halves, bottom offset by 32
    assign pixel_x        = pos_bus.col;
    assign pixel_y[0]     = {1'b0, pos_bus.row};
    assign pixel_y[1]     = {1'b1, pos_bus.row};
    assign pixel_frame    = pos_bus.frame;
    assign pixel_subframe = pos_bus.subframe;

    scan_sequencer i_scan_sequencer (
        .clk       (clk),
        .ext_reset (ext_reset),
        .step      (step),
        .pos       (pos_bus.source)
    );

    gamma_lut i_gamma_lut (
        .clk        (clk),
        .ext_reset  (ext_reset),
        .pos        (pos_bus.sink),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .color      (color_bus.source)
    );

    pdm_modulator i_pdm_modulator (
        .clk         (clk),
        .ext_reset   (ext_reset),
        .pos         (pos_bus.sink),
        .color       (color_bus.sink),
        .mem_ready   (mem_ready),
        .bits_top    (bits_top),
        .bits_bottom (bits_bottom),
        .bits_row    (bits_row),
        .bits_valid  (bits_valid)
    );

    panel_driver i_panel_driver (
        .clk              (clk),
        .ext_reset        (ext_reset),
        .mem_ready        (mem_ready),
        .bits_top         (bits_top),
        .bits_bottom      (bits_bottom),
        .bits_row         (bits_row),
        .bits_valid       (bits_valid),
        .step             (step),
        .panel_rgb_top    (panel_rgb_top),
        .panel_rgb_bottom (panel_rgb_bottom),
        .panel_addr       (panel_addr),
        .panel_blank      (panel_blank),
        .panel_latch      (panel_latch),
        .panel_sclk       (panel_sclk)
    );

endmodule

`default_nettype wire

// File: design/panel_driver.sv
`default_nettype none

`include "led_panel_params.svh"

module panel_driver (
    input  wire logic                 clk,
    input  wire logic                 ext_reset,
    input  wire logic                 mem_ready,
    input  wire led_panel_pkg::rgb3_t bits_top,
    input  wire led_panel_pkg::rgb3_t bits_bottom,
    input  wire led_panel_pkg::row_t  bits_row,
    input  wire logic                 bits_valid,
    output logic                      step,
    output led_panel_pkg::rgb3_t      panel_rgb_top,
    output led_panel_pkg::rgb3_t      panel_rgb_bottom,
    output led_panel_pkg::row_t       panel_addr,
    output logic                      panel_blank,
    output logic                      panel_latch,
    output logic                      panel_sclk
);

    led_panel_pkg::drv_state_t state;
    led_panel_pkg::col_t       col_cnt;      // columns shifted in this row
    led_panel_pkg::rgb3_t      hold_top;
    led_panel_pkg::rgb3_t      hold_bottom;
    led_panel_pkg::row_t       hold_row;
    led_panel_pkg::row_t       last_row;     // row that goes out on the next latch
    logic                      hold_full;
    logic                      take;

    // one column buffer, so a result arriving outside shift_low is kept
    assign take = (state == led_panel_pkg::shift_low) && hold_full;

    always_ff @(posedge clk) begin
        if (bits_valid) begin
            hold_top    <= bits_top;
            hold_bottom <= bits_bottom;
            hold_row    <= bits_row;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            panel_rgb_top    <= hold_top;
            panel_rgb_bottom <= hold_bottom;
            last_row         <= hold_row;
        end
    end

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            state       <= led_panel_pkg::wait_clear;
            col_cnt     <= '0;
            hold_full   <= 1'b0;
            step        <= 1'b0;
            panel_addr  <= '0;
            panel_blank <= 1'b1;    // dark until the first row is latched
            panel_latch <= 1'b0;
            panel_sclk  <= 1'b0;
        end else begin
            hold_full <= bits_valid | (hold_full & ~take);
            step      <= 1'b0;
            case (state)
                led_panel_pkg::wait_clear: begin
                    if (mem_ready) begin
                        state <= led_panel_pkg::shift_low;
                    end
                end
                led_panel_pkg::shift_low: begin
                    panel_sclk <= 1'b0;
                    if (hold_full) begin
                        state <= led_panel_pkg::shift_high;
                    end
                end
                led_panel_pkg::shift_high: begin
                    panel_sclk <= 1'b1;    // data was set up a cycle earlier
                    step       <= 1'b1;
                    col_cnt    <= col_cnt + 1'b1;
                    if (col_cnt == led_panel_pkg::col_t'(`LP_COLS - 1)) begin
                        state <= led_panel_pkg::blank;
                    end else begin
                        state <= led_panel_pkg::shift_low;
                    end
                end
                led_panel_pkg::blank: begin
                    panel_sclk  <= 1'b0;
                    panel_blank <= 1'b1;
                    state       <= led_panel_pkg::latch;
                end
                led_panel_pkg::latch: begin
                    panel_latch <= 1'b1;
                    state       <= led_panel_pkg::unblank;
                end
                led_panel_pkg::unblank: begin
                    panel_latch <= 1'b0;
                    panel_blank <= 1'b0;
                    panel_addr  <= last_row;    // new row shows with fresh data
                    state       <= led_panel_pkg::shift_low;
                end
                default: begin
                    state <= led_panel_pkg::wait_clear;
                end
            endcase
        end
    end

    // blank has to be up before latch and stay up through it
    a_latch_blanked: assert property (
        @(posedge clk) disable iff (!ext_reset)
        panel_latch |-> panel_blank && $past(panel_blank)
    ) else $error("latch outside blanking");

endmodule

`default_nettype wire

// File: design/pdm_modulator.sv
`default_nettype none

`include "led_panel_params.svh"

module pdm_modulator (
    input  wire logic              clk,
    input  wire logic              ext_reset,
    pixel_pos_if.sink              pos,
    color_if.sink                  color,
    output logic                   mem_ready,
    output led_panel_pkg::rgb3_t   bits_top,
    output led_panel_pkg::rgb3_t   bits_bottom,
    output led_panel_pkg::row_t    bits_row,
    output logic                   bits_valid
);

    localparam int gb        = `LP_GAMMA_BITS;
    localparam int chans     = 6;               // rgb for top and bottom half
    localparam int word_bits = chans * gb;
    localparam int addr_bits = $clog2(`LP_CLEAR_COUNT);

    localparam logic [gb-1:0] err_max = '1;

    logic [word_bits-1:0] err_mem [0:`LP_CLEAR_COUNT-1];
    logic [word_bits-1:0] err_q;                 // arrives together with color
    logic [word_bits-1:0] err_next;
    logic [word_bits-1:0] x_all;
    logic [chans-1:0]     bits_next;
    logic [addr_bits:0]   clear_cnt;

    assign mem_ready = (clear_cnt == (addr_bits + 1)'(`LP_CLEAR_COUNT));

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            clear_cnt <= '0;
        end else if (!mem_ready) begin
            clear_cnt <= clear_cnt + 1'b1;
        end
    end

    // read one pixel ahead, gamma takes the same cycle
    always_ff @(posedge clk) begin
        if (pos.valid) begin
            err_q <= err_mem[{pos.row, pos.col}];
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_ready) begin
            err_mem[clear_cnt[addr_bits-1:0]] <= '0;
        end else if (color.valid) begin
            err_mem[{color.row, color.col}] <= err_next;
        end
    end

    assign x_all = {color.rgb_top, color.rgb_bottom};    // top red in the msbs

    // first order error diffusion over time, per channel
    always_comb begin : calc
        logic [gb-1:0] x;
        logic [gb-1:0] e;
        for (int i = 0; i < chans; i++) begin
            x = x_all[i*gb +: gb];
            e = err_q[i*gb +: gb];
            if (x > e) begin
                bits_next[i]         = 1'b1;
                err_next[i*gb +: gb] = err_max - (x - e);
            end else begin
                bits_next[i]         = 1'b0;
                err_next[i*gb +: gb] = e - x;
            end
        end
    end

    always_ff @(posedge clk) begin
        bits_top    <= bits_next[5:3];
        bits_bottom <= bits_next[2:0];
        bits_row    <= color.row;
    end

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            bits_valid <= 1'b0;
        end else begin
            bits_valid <= color.valid;
        end
    end

    // scan start must wait for the clear, otherwise write-back collides with it
    a_no_color_before_ready: assert property (
        @(posedge clk) disable iff (!ext_reset)
        color.valid |-> mem_ready
    ) else $error("colour arrived while error memory was clearing");

endmodule

`default_nettype wire

// File: design/scan_sequencer.sv
`default_nettype none

`include "led_panel_params.svh"

module scan_sequencer (
    input  wire logic   clk,
    input  wire logic   ext_reset,
    input  wire logic   step,
    pixel_pos_if.source pos
);

    localparam int count_bits = `LP_FRAME_BITS + `LP_SUBFRAME_BITS
                              + `LP_ROW_BITS + `LP_COL_BITS;
    localparam int wait_bits  = $clog2(`LP_CLEAR_COUNT) + 1;

    logic [count_bits-1:0] count;       // {frame, subframe, row, col}
    logic [wait_bits-1:0]  wait_cnt;
    logic                  primed;
    logic                  valid_q;

    // the first position is only issued once the error memory has been wiped,
    // so its result is not computed against stale memory contents
    assign primed = (wait_cnt == wait_bits'(`LP_CLEAR_COUNT));

    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            count    <= '0;
            wait_cnt <= '0;
            valid_q  <= 1'b0;
        end else begin
            if (!primed) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            if (step) begin
                count <= count + 1'b1;    // col, row, subframe, frame carry in turn
            end
            valid_q <= step || (wait_cnt == wait_bits'(`LP_CLEAR_COUNT - 1));
        end
    end

    assign {pos.frame, pos.subframe, pos.row, pos.col} = count;
    assign pos.valid = valid_q;

    // the driver needs at least a low and a high phase per column
    a_step_single: assert property (
        @(posedge clk) disable iff (!ext_reset)
        step |=> !step
    ) else $error("step held high for two cycles");

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/led_panel_pkg.sv
design/led_panel_if.sv
design/scan_sequencer.sv
design/gamma_lut.sv
design/pdm_modulator.sv
design/panel_driver.sv
design/led_panel_top.sv
verif/tb_led_panel.sv

// File: verif/led_panel_trace.txt
# test name, top colour and bottom colour as rrggbb hex, subframes to check
# every pixel of the panel shows the colours of its line
black       000000 000000 1
white       ffffff ffffff 1
mid_gray    808080 808080 4
mid_mix     40c0a0 a06020 3
halves      c0c0c0 202020 2
map_red_grn ff0000 00ff00 1
map_blu_mag 0000ff ff00ff 1

// File: verif/tb_led_panel.sv
`default_nettype none

`include "led_panel_params.svh"

module tb_led_panel;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int rows       = 1 << `LP_ROW_BITS;
    localparam int wait_limit = `LP_CLEAR_COUNT + 64;    // cycles without progress

    logic                         clk;
    logic                         ext_reset;
    logic [`LP_COL_BITS-1:0]      pixel_x;
    logic [1:0][`LP_ROW_BITS:0]   pixel_y;
    logic [`LP_FRAME_BITS-1:0]    pixel_frame;
    logic [`LP_SUBFRAME_BITS-1:0] pixel_subframe;
    led_panel_pkg::rgb24_t        rgb_top;
    led_panel_pkg::rgb24_t        rgb_bottom;
    led_panel_pkg::rgb3_t         panel_rgb_top;
    led_panel_pkg::rgb3_t         panel_rgb_bottom;
    led_panel_pkg::row_t          panel_addr;
    logic                         panel_blank;
    logic                         panel_latch;
    logic                         panel_sclk;

    string test_name;
    int    checks;
    int    errors;
    int    test_errors;
    bit    run_aborted;

    led_panel_top i_led_panel_top (
        .clk              (clk),
        .ext_reset        (ext_reset),
        .pixel_x          (pixel_x),
        .pixel_y          (pixel_y),
        .pixel_frame      (pixel_frame),
        .pixel_subframe   (pixel_subframe),
        .rgb_top          (rgb_top),
        .rgb_bottom       (rgb_bottom),
        .panel_rgb_top    (panel_rgb_top),
        .panel_rgb_bottom (panel_rgb_bottom),
        .panel_addr       (panel_addr),
        .panel_blank      (panel_blank),
        .panel_latch      (panel_latch),
        .panel_sclk       (panel_sclk)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int gamma_of(input int c);
        return (c * c * 1023 + 32512) / 65025;    // square law, rounded
    endfunction

    // subframe bit of one channel, error starts at zero after reset
    function automatic bit pdm_bit(input int c, input int sf);
        int g;
        int e;
        bit b;
        g = gamma_of(c);
        e = 0;
        b = 1'b0;
        for (int i = 0; i <= sf; i++) begin
            b = (g > e);
            e = b ? 1023 - (g - e) : e - g;
        end
        return b;
    endfunction

    function automatic logic [2:0] pdm_bits(input led_panel_pkg::rgb24_t c, input int sf);
        return {pdm_bit(c.r, sf), pdm_bit(c.g, sf), pdm_bit(c.b, sf)};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout in test %s, %s", test_name, why);
        run_aborted = 1'b1;
    endtask

    // checks the columns of one row up to its latch pulse
    task automatic scan_row(input int row, input int sf, input logic [2:0] exp_top,
                            input logic [2:0] exp_bottom);
        int cols;
        int idle;
        cols = 0;
        idle = 0;
        forever begin
            @(negedge clk);    // outputs settled mid cycle
            if (panel_latch) begin
                break;
            end
            if (panel_sclk) begin
                if (row == 0 && sf == 0 && cols == 0) begin
                    compare_value("clear before first sclk", 1, idle >= `LP_CLEAR_COUNT);
                end
                compare_value("pixel_x", cols, pixel_x);
                compare_value("pixel_y top", row, pixel_y[0]);
                compare_value("pixel_y bottom", row + rows, pixel_y[1]);
                compare_value("pixel_subframe", sf, pixel_subframe);
                compare_value("pixel_frame", sf >> `LP_SUBFRAME_BITS, pixel_frame);
                compare_value("panel_rgb_top", exp_top, panel_rgb_top);
                compare_value("panel_rgb_bottom", exp_bottom, panel_rgb_bottom);
                cols++;
                idle = 0;
                if (cols > `LP_COLS) begin
                    abort_run($sformatf("more than %0d sclk pulses in row %0d",
                                        `LP_COLS, row));
                    return;
                end
            end else begin
                idle++;
            end
            if (idle > wait_limit) begin
                abort_run($sformatf("no sclk or latch in row %0d", row));
                return;
            end
        end
        compare_value("sclk pulses per row", `LP_COLS, cols);
        compare_value("blank during latch", 1, panel_blank);
        idle = 0;
        while (panel_blank) begin
            @(negedge clk);
            idle++;
            if (idle > wait_limit) begin
                abort_run("panel stays blanked after latch");
                return;
            end
        end
        compare_value("panel_addr", row, panel_addr);
    endtask

    task automatic run_test(input led_panel_pkg::rgb24_t top,
                            input led_panel_pkg::rgb24_t bottom, input int sfs);
        @(posedge clk);
        #2;
        ext_reset  = 1'b0;    // fresh reset also wipes the error memory
        rgb_top    = top;
        rgb_bottom = bottom;
        repeat (2) @(posedge clk);
        #2;
        ext_reset = 1'b1;
        @(negedge clk);
        compare_value("blank after reset", 1, panel_blank);
        compare_value("latch after reset", 0, panel_latch);
        compare_value("sclk after reset", 0, panel_sclk);
        for (int sf = 0; sf < sfs; sf++) begin
            for (int row = 0; row < rows; row++) begin
                scan_row(row, sf, pdm_bits(top, sf), pdm_bits(bottom, sf));
                if (run_aborted) begin
                    return;
                end
            end
        end
    endtask

    initial begin : main
        int    fd;
        int    n;
        int    top_v;
        int    bottom_v;
        int    sfs;
        int    tests_run;
        int    tests_failed;
        string line;
        ext_reset    = 1'b0;
        rgb_top      = '0;
        rgb_bottom   = '0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        run_aborted  = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "none";
        fd = $fopen("verif/led_panel_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open trace file verif/led_panel_trace.txt");
            run_aborted = 1'b1;
        end
        while (fd != 0 && !run_aborted && !$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%s %h %h %d", test_name, top_v, bottom_v, sfs);
            if (n == 4 && test_name.getc(0) != "#") begin    // skip comments and blanks
                test_errors = 0;
                run_test(top_v[23:0], bottom_v[23:0], sfs);
                tests_run++;
                if (test_errors == 0 && !run_aborted) begin
                    $display("test %s passed over %0d subframes", test_name, sfs);
                end else begin
                    tests_failed++;
                    $display("test %s failed with %0d mismatches", test_name, test_errors);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (tests_run == 0) begin
            $display("no tests were found in the trace file");
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (!run_aborted && errors == 0 && tests_failed == 0 && tests_run > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
